// File: compile.f
+incdir+rtl
+incdir+sim
rtl/creditFifoPkg.sv
rtl/creditCounter.sv
rtl/fifoCtrl.sv
rtl/flopRam1r1w.sv
rtl/creditFifoFlops.sv
sim/tbCreditFifo.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = tbCreditFifo
FILELIST  = compile.f
OBJ_DIR   = obj_dir
LOG       = sim.log

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# The simulator status is ignored here, the log decides
run: compile
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -qx "TEST OK" $(LOG); then \
		echo "Simulation passed"; \
	else \
		echo "Simulation failed"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: sim/tbCreditFifoStim.svh
`ifndef TB_CREDIT_FIFO_STIM_SVH
`define TB_CREDIT_FIFO_STIM_SVH

// Each row lists creditInit, creditHold, stallMask, numWords, readyPct and expCount
// Bit n of stallMask stalls credit return in cycle n of every eight in the mixed phase
// readyPct is the chance in percent that popReady is high in a cycle
// expCount is the creditCount left once every earned credit has gone back

localparam int NumRows = 7;

localparam stimRow_t StimTable [NumRows] = '{
  // All credits handed out at once fill the FIFO, then steady traffic
  '{4'd8, 4'd0, 8'h00, 8'd20, 8'd60, 4'd0},
  // Part withheld, stall during half of every eight cycles
  '{4'd6, 4'd2, 8'hF0, 8'd24, 8'd50, 4'd2},
  // Everything withheld, so the sender never gets a credit
  '{4'd4, 4'd4, 8'h00, 8'd0, 8'd100, 4'd4},
  // More withheld than loaded
  '{4'd3, 4'd5, 8'h0F, 8'd0, 8'd70, 4'd3},
  // Slow consumer with a scattered stall
  '{4'd7, 4'd1, 8'hCC, 8'd30, 8'd30, 4'd1},
  // Credit return mostly stalled, only two credits in flight
  '{4'd2, 4'd0, 8'hFE, 8'd16, 8'd90, 4'd0},
  '{4'd8, 4'd3, 8'h3C, 8'd12, 8'd75, 4'd3}
};

`endif

// File: sim/tbCreditFifo.sv
`timescale 1ns/1ps
`default_nettype none

`include "creditFifo_defs.svh"

module tbCreditFifo;

  localparam int PhaseTimeout = 2000;

  // One row of the stimulus table
  typedef struct packed {
    logic [3:0] creditInit;
    logic [3:0] creditHold;
    logic [7:0] stallMask;
    logic [7:0] numWords;
    logic [7:0] readyPct;
    logic [3:0] expCount;
  } stimRow_t;

  `include "tbCreditFifoStim.svh"

  logic                   clk;
  logic                   arstN;
  logic                   pushCreditStall;
  logic                   pushValid;
  creditFifoPkg::data_t   pushData;
  logic                   popReady;
  creditFifoPkg::credit_t creditInitial;
  creditFifoPkg::credit_t creditWithhold;
  logic                   pushCredit;
  logic                   popValid;
  creditFifoPkg::data_t   popData;
  logic                   full;
  logic                   empty;
  creditFifoPkg::count_t  items;
  creditFifoPkg::count_t  slots;
  creditFifoPkg::credit_t creditCount;
  creditFifoPkg::credit_t creditAvailable;

  // ----------------------------------------
  // Reference model state
  // ----------------------------------------

  // Words accepted by the FIFO and not yet popped, oldest first
  creditFifoPkg::data_t modelQueue[$];
  stimRow_t             curRow;
  logic [31:0]          rngState;
  // Credits the FIFO still owes the sender
  int                   modelCount;
  logic                 modelInit;
  // Credits received by the sender and not yet spent
  int                   creditsHeld;
  int                   pulses;
  int                   pops;
  int                   pushedReq;
  logic                 pushDriven;
  logic                 pushedLastEdge;
  logic                 holdPending;
  creditFifoPkg::data_t holdData;
  logic                 fullSeen;

  creditFifoFlops dut0 (
    .clk             (clk),
    .arstN           (arstN),
    .pushCreditStall (pushCreditStall),
    .pushValid       (pushValid),
    .pushData        (pushData),
    .popReady        (popReady),
    .creditInitial   (creditInitial),
    .creditWithhold  (creditWithhold),
    .pushCredit      (pushCredit),
    .popValid        (popValid),
    .popData         (popData),
    .full            (full),
    .empty           (empty),
    .items           (items),
    .slots           (slots),
    .creditCount     (creditCount),
    .creditAvailable (creditAvailable)
  );

  always #2 clk = ~clk;

  function automatic logic [31:0] nextRandom();
    rngState = rngState ^ (rngState << 13);
    rngState = rngState ^ (rngState >> 17);
    rngState = rngState ^ (rngState << 5);
    return rngState;
  endfunction

  // Counted credits minus the withheld part, never below zero
  function automatic int modelAvail();
    int hold;
    hold = int'(curRow.creditHold);
    return (modelCount > hold) ? modelCount - hold : 0;
  endfunction

  task automatic reportFailure(input string why);
    $display("%s", why);
    $display("TEST FAILED");
    $fatal(1, "simulation stopped on the first error");
  endtask

  task automatic checkValue(input string name, input logic [31:0] expected,
                            input logic [31:0] actual);
    if (actual !== expected) begin
      reportFailure($sformatf("CHECK FAILED at %0t: %s expected 0x%0h actual 0x%0h",
                              $time, name, expected, actual));
    end
  endtask

  // ----------------------------------------
  // Reset and cycle stepping
  // ----------------------------------------

  task automatic applyReset(input stimRow_t row);
    @(posedge clk);
    arstN           <= 1'b0;
    pushValid       <= 1'b0;
    popReady        <= 1'b0;
    pushCreditStall <= 1'b0;
    creditInitial   <= row.creditInit;
    creditWithhold  <= row.creditHold;
    curRow         = row;
    modelQueue.delete();
    modelCount     = 0;
    modelInit      = 1'b0;
    creditsHeld    = 0;
    pulses         = 0;
    pops           = 0;
    pushedReq      = 0;
    pushDriven     = 1'b0;
    pushedLastEdge = 1'b0;
    holdPending    = 1'b0;
    repeat (2) @(posedge clk);
    // Values while reset is still held
    @(negedge clk);
    checkValue("popValid", 32'd0, 32'(popValid));
    checkValue("empty", 32'd1, 32'(empty));
    checkValue("full", 32'd0, 32'(full));
    checkValue("items", 32'd0, 32'(items));
    checkValue("slots", 32'(`CF_DEPTH), 32'(slots));
    checkValue("pushCredit", 32'd0, 32'(pushCredit));
    @(posedge clk);
    arstN <= 1'b1;
  endtask

  // Checks the outputs at the falling edge, books the transfers of the coming
  // rising edge in the model, then drives the next inputs
  task automatic stepCycle(input logic stallNext, input int readyPct);
    logic expPopValid;
    logic expCredit;
    logic fire;
    @(negedge clk);
    // A word pushed into an empty FIFO needs one more edge to reach the pop register
    expPopValid = (modelQueue.size() > 1) || (modelQueue.size() == 1 && !pushedLastEdge);
    expCredit = modelInit && (modelAvail() != 0) && !pushCreditStall;
    checkValue("items", 32'(modelQueue.size()), 32'(items));
    checkValue("slots", 32'(`CF_DEPTH - modelQueue.size()), 32'(slots));
    checkValue("full", 32'(modelQueue.size() == `CF_DEPTH), 32'(full));
    checkValue("empty", 32'(modelQueue.size() == 0), 32'(empty));
    checkValue("popValid", 32'(expPopValid), 32'(popValid));
    checkValue("creditCount", 32'(modelCount), 32'(creditCount));
    checkValue("creditAvailable", 32'(modelAvail()), 32'(creditAvailable));
    checkValue("pushCredit", 32'(expCredit), 32'(pushCredit));
    if (holdPending) begin
      checkValue("popValid under back-pressure", 32'd1, 32'(popValid));
      checkValue("popData under back-pressure", 32'(holdData), 32'(popData));
    end
    holdPending = popValid && !popReady;
    holdData    = popData;
    if (modelQueue.size() == `CF_DEPTH) fullSeen = 1'b1;
    fire = popValid && popReady;
    if (fire) begin
      checkValue("popData", 32'(modelQueue[0]), 32'(popData));
      void'(modelQueue.pop_front());
      pops++;
    end
    pushedLastEdge = pushValid;
    if (pushValid) modelQueue.push_back(pushData);
    // The sender counts the credit pulses it actually sees from the FIFO
    if (pushCredit) begin
      creditsHeld++;
      pulses++;
    end
    if (!modelInit) begin
      modelInit  = 1'b1;
      modelCount = int'(curRow.creditInit);
    end else begin
      modelCount = modelCount + int'(fire) - int'(expCredit);
    end
    @(posedge clk);
    // The sender spends one held credit per word
    pushDriven = (creditsHeld > 0) && (pushedReq < int'(curRow.numWords));
    if (pushDriven) begin
      creditsHeld--;
      pushedReq++;
    end
    pushValid       <= pushDriven;
    pushData        <= creditFifoPkg::data_t'(nextRandom());
    popReady        <= (nextRandom() % 100) < readyPct;
    pushCreditStall <= stallNext;
  endtask

  // ----------------------------------------
  // One table row
  // ----------------------------------------

  task automatic runRow(input stimRow_t row);
    int cycles;
    int initCredits;
    initCredits = (int'(row.creditInit) > int'(row.creditHold)) ?
                  int'(row.creditInit) - int'(row.creditHold) : 0;
    applyReset(row);
    // Consumer stalled, so only the initial credits reach the sender
    cycles = 0;
    while (!(modelInit && modelAvail() == 0 &&
             (creditsHeld == 0 || pushedReq == int'(row.numWords)))) begin
      stepCycle(1'b0, 0);
      cycles++;
      if (cycles > PhaseTimeout) reportFailure("Timeout while initial credits were handed out");
    end
    checkValue("initial credit pulses", 32'(initCredits), 32'(pulses));
    // Mixed traffic with random popReady and the row's stall pattern
    cycles = 0;
    while (!(pushedReq == int'(row.numWords) && !pushDriven && modelQueue.size() == 0)) begin
      stepCycle(row.stallMask[cycles[2:0]], int'(row.readyPct));
      cycles++;
      if (cycles > PhaseTimeout) reportFailure("Timeout before all words came out of the FIFO");
    end
    // Stall released, every credit earned by a pop has to come back
    cycles = 0;
    while (modelAvail() != 0) begin
      stepCycle(1'b0, 0);
      cycles++;
      if (cycles > PhaseTimeout) reportFailure("Timeout while earned credits were returned");
    end
    @(negedge clk);
    checkValue("final creditCount", 32'(row.expCount), 32'(creditCount));
    checkValue("total credit pulses",
               32'(int'(row.creditInit) - int'(row.expCount) + pops), 32'(pulses));
  endtask

  initial begin
    clk = 1'b0;
    arstN           <= 1'b0;
    pushCreditStall <= 1'b0;
    pushValid       <= 1'b0;
    pushData        <= '0;
    popReady        <= 1'b0;
    creditInitial   <= '0;
    creditWithhold  <= '0;
    rngState = 32'h74938f33;
    fullSeen = 1'b0;
    for (int r = 0; r < NumRows; r++) begin
      runRow(StimTable[r]);
    end
    // At least one row must have filled the FIFO completely
    checkValue("full reached", 32'd1, 32'(fullSeen));
    $display("TEST OK");
    $finish;
  end

endmodule

`default_nettype wire

// File: rtl/creditFifoFlops.sv
`timescale 1ns/1ps
`default_nettype none

module creditFifoFlops (
  input  wire logic                   clk,
  input  wire logic                   arstN,
  input  wire logic                   pushCreditStall,
  input  wire logic                   pushValid,
  input  wire creditFifoPkg::data_t   pushData,
  input  wire logic                   popReady,
  input  wire creditFifoPkg::credit_t creditInitial,
  input  wire creditFifoPkg::credit_t creditWithhold,
  output logic                        pushCredit,
  output logic                        popValid,
  output creditFifoPkg::data_t        popData,
  output logic                        full,
  output logic                        empty,
  output creditFifoPkg::count_t       items,
  output creditFifoPkg::count_t       slots,
  output creditFifoPkg::credit_t      creditCount,
  output creditFifoPkg::credit_t      creditAvailable
);

  // ----------------------------------------
  // Internal nets
  // ----------------------------------------

  // Controller to RAM
  logic                 ramWrValid;
  creditFifoPkg::addr_t ramWrAddr;
  creditFifoPkg::data_t ramWrData;
  creditFifoPkg::addr_t ramRdAddr;
  creditFifoPkg::data_t ramRdData;

  // Each pop transfer earns one credit back
  logic popFire;

  fifoCtrl ctrl0 (
    .clk        (clk),
    .arstN      (arstN),
    .pushValid  (pushValid),
    .pushData   (pushData),
    .popReady   (popReady),
    .ramRdData  (ramRdData),
    .ramWrValid (ramWrValid),
    .ramWrAddr  (ramWrAddr),
    .ramWrData  (ramWrData),
    .ramRdAddr  (ramRdAddr),
    .popValid   (popValid),
    .popData    (popData),
    .popFire    (popFire),
    .items      (items),
    .slots      (slots),
    .full       (full),
    .empty      (empty)
  );

  creditCounter credit0 (
    .clk             (clk),
    .arstN           (arstN),
    .creditInitial   (creditInitial),
    .creditWithhold  (creditWithhold),
    .pushCreditStall (pushCreditStall),
    .popFire         (popFire),
    .pushCredit      (pushCredit),
    .creditCount     (creditCount),
    .creditAvailable (creditAvailable)
  );

  // Storage has no reset, only the controller state does
  flopRam1r1w ram0 (
    .clk     (clk),
    .wrValid (ramWrValid),
    .wrAddr  (ramWrAddr),
    .wrData  (ramWrData),
    .rdAddr  (ramRdAddr),
    .rdData  (ramRdData)
  );

endmodule

`default_nettype wire

// File: rtl/flopRam1r1w.sv
`timescale 1ns/1ps
`default_nettype none

`include "creditFifo_defs.svh"

module flopRam1r1w (
  input  wire logic                 clk,
  input  wire logic                 wrValid,
  input  wire creditFifoPkg::addr_t wrAddr,
  input  wire creditFifoPkg::data_t wrData,
  input  wire creditFifoPkg::addr_t rdAddr,
  output creditFifoPkg::data_t      rdData
);

  // ----------------------------------------
  // Storage
  // ----------------------------------------

  // One flop word per FIFO entry
  creditFifoPkg::data_t mem [`CF_DEPTH];

  // Cells start undefined, the controller reads a cell only after writing it
  always_ff @(posedge clk) begin
    if (wrValid) begin
      mem[wrAddr] <= wrData;
    end
  end

  // ----------------------------------------
  // Read port
  // ----------------------------------------

  // Read is combinational and sees the old contents during a same-cycle write,
  // the FIFO never reads and writes one cell in the same cycle anyway
  assign rdData = mem[rdAddr];

endmodule

`default_nettype wire

// File: rtl/fifoCtrl.sv
`timescale 1ns/1ps
`default_nettype none

`include "creditFifo_defs.svh"

module fifoCtrl (
  input  wire logic                 clk,
  input  wire logic                 arstN,
  input  wire logic                 pushValid,
  input  wire creditFifoPkg::data_t pushData,
  input  wire logic                 popReady,
  input  wire creditFifoPkg::data_t ramRdData,
  output logic                      ramWrValid,
  output creditFifoPkg::addr_t      ramWrAddr,
  output creditFifoPkg::data_t      ramWrData,
  output creditFifoPkg::addr_t      ramRdAddr,
  output logic                      popValid,
  output creditFifoPkg::data_t      popData,
  output logic                      popFire,
  output creditFifoPkg::count_t     items,
  output creditFifoPkg::count_t     slots,
  output logic                      full,
  output logic                      empty
);

  localparam creditFifoPkg::addr_t  LastAddr = creditFifoPkg::addr_t'(`CF_DEPTH - 1);
  localparam creditFifoPkg::count_t DepthCnt = creditFifoPkg::count_t'(`CF_DEPTH);

  creditFifoPkg::addr_t     wrPtr;
  creditFifoPkg::addr_t     rdPtr;
  // Words in the RAM only, the pop register is not included
  creditFifoPkg::count_t    ramCount;
  creditFifoPkg::popState_t popState;
  logic                     popLoad;

  // ----------------------------------------
  // RAM write side
  // ----------------------------------------

  // Every accepted push goes straight into the RAM, there is no bypass
  assign ramWrValid = pushValid;
  assign ramWrAddr  = wrPtr;
  assign ramWrData  = pushData;

  // The read address always points at the oldest RAM word
  assign ramRdAddr = rdPtr;

  // ----------------------------------------
  // Pop stage
  // ----------------------------------------

  assign popValid = (popState == creditFifoPkg::popHolding);
  assign popFire  = popValid && popReady;

  // Refill the pop register when it is empty or being emptied this cycle
  assign popLoad = (ramCount != '0) &&
                   ((popState == creditFifoPkg::popEmpty) || popFire);

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      popState <= creditFifoPkg::popEmpty;
    end else begin
      case (popState)
        creditFifoPkg::popEmpty: begin
          if (popLoad) popState <= creditFifoPkg::popHolding;
        end
        creditFifoPkg::popHolding: begin
          // Stay holding if a new word replaces the one just taken
          if (popFire && !popLoad) popState <= creditFifoPkg::popEmpty;
        end
        default: popState <= creditFifoPkg::popEmpty;
      endcase
    end
  end

  // Payload register, qualified by popState
  always_ff @(posedge clk) begin
    if (popLoad) popData <= ramRdData;
  end

  // ----------------------------------------
  // Pointers and occupancy
  // ----------------------------------------

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      wrPtr    <= '0;
      rdPtr    <= '0;
      ramCount <= '0;
      items    <= '0;
    end else begin
      if (pushValid) wrPtr <= (wrPtr == LastAddr) ? '0 : wrPtr + 1'b1;
      if (popLoad)   rdPtr <= (rdPtr == LastAddr) ? '0 : rdPtr + 1'b1;
      ramCount <= ramCount + creditFifoPkg::count_t'(pushValid)
                           - creditFifoPkg::count_t'(popLoad);
      // Total occupancy moves only on the external push and pop transfers
      items <= items + creditFifoPkg::count_t'(pushValid)
                     - creditFifoPkg::count_t'(popFire);
    end
  end

  assign slots = DepthCnt - items;
  assign full  = (items == DepthCnt);
  assign empty = (items == '0);

  // ----------------------------------------
  // Checks
  // ----------------------------------------

  // The sender only pushes against credits, so a full FIFO never sees a push
  noPushWhenFull: assert property (
    @(posedge clk) disable iff (!arstN)
    pushValid |-> !full
  ) else $error("push while FIFO full");

  // A stalled pop word must wait unchanged for the consumer
  popStable: assert property (
    @(posedge clk) disable iff (!arstN)
    (popValid && !popReady) |=> (popValid && $stable(popData))
  ) else $error("pop output changed under back-pressure");

endmodule

`default_nettype wire

// File: rtl/creditCounter.sv
`timescale 1ns/1ps
`default_nettype none

`include "creditFifo_defs.svh"

module creditCounter (
  input  wire logic                  clk,
  input  wire logic                  arstN,
  input  wire creditFifoPkg::credit_t creditInitial,
  input  wire creditFifoPkg::credit_t creditWithhold,
  input  wire logic                  pushCreditStall,
  input  wire logic                  popFire,
  output logic                       pushCredit,
  output creditFifoPkg::credit_t     creditCount,
  output creditFifoPkg::credit_t     creditAvailable
);

  // Low until the initial credit amount has been loaded
  logic initDone;

  // ----------------------------------------
  // Credit accounting
  // ----------------------------------------

  // Withheld credits stay counted but are never offered to the sender
  assign creditAvailable = (creditCount > creditWithhold) ?
                           creditCount - creditWithhold : '0;

  // One credit leaves per cycle while some are available and the sender accepts them
  assign pushCredit = initDone && (creditAvailable != '0) && !pushCreditStall;

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      initDone    <= 1'b0;
      creditCount <= '0;
    end else if (!initDone) begin
      // First cycle out of reset takes the programmed starting amount
      initDone    <= 1'b1;
      creditCount <= creditInitial;
    end else begin
      // A pop earns a credit back and an issued credit leaves the count,
      // both in the same cycle cancel out
      creditCount <= creditCount
                   + creditFifoPkg::credit_t'(popFire)
                   - creditFifoPkg::credit_t'(pushCredit);
    end
  end

  // ----------------------------------------
  // Checks
  // ----------------------------------------

  // More initial credits than entries would let the sender overrun the RAM
  initialAmount: assert property (
    @(posedge clk) disable iff (!arstN)
    !initDone |-> (creditInitial <= creditFifoPkg::credit_t'(`CF_DEPTH))
  ) else $error("creditInitial exceeds FIFO depth");

  // A pop means one word sits in the FIFO, so the count must be below the depth
  // and the increment cannot wrap
  noOverflow: assert property (
    @(posedge clk) disable iff (!arstN)
    popFire |-> (creditCount < creditFifoPkg::credit_t'(`CF_DEPTH))
  ) else $error("credit count overflow on pop");

endmodule

`default_nettype wire

// File: rtl/creditFifoPkg.sv
`default_nettype none

`include "creditFifo_defs.svh"

package creditFifoPkg;

  // Widths with a meaning of their own
  typedef logic [`CF_WIDTH-1:0]    data_t;
  typedef logic [`CF_ADDR_W-1:0]   addr_t;
  typedef logic [`CF_COUNT_W-1:0]  count_t;
  typedef logic [`CF_CREDIT_W-1:0] credit_t;

  // State of the registered pop stage
  // popEmpty means popData holds nothing, popHolding means a word waits for popReady
  typedef enum logic {
    popEmpty,
    popHolding
  } popState_t;

endpackage

`default_nettype wire

// File: rtl/creditFifo_defs.svh
`ifndef CREDIT_FIFO_DEFS_SVH
`define CREDIT_FIFO_DEFS_SVH

// Number of FIFO entries, counting the pop register
`define CF_DEPTH 8

// Width of one data word
`define CF_WIDTH 16

// RAM address width, enough to index CF_DEPTH entries
`define CF_ADDR_W 3

// Item and slot counts must reach CF_DEPTH itself, so one bit more than the address
`define CF_COUNT_W 4

// The credit counter never holds more than CF_DEPTH credits
`define CF_CREDIT_W 4

`endif
